/* src/serial_pkg.sv */
package serial_pkg;

   // datapath word width, one bit of it is processed per clock
   localparam int XLEN  = 32;

   // register file geometry, x0 is hardwired to zero
   localparam int NREGS = 8;
   localparam int REG_W = 3;

   // opcode sits in bits 31..29 of the instruction word
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_ADDI = 3'd2,
      OP_SLT  = 3'd3,
      OP_BEQ  = 3'd4,
      OP_BNE  = 3'd5,
      OP_JAL  = 3'd6,
      OP_OUT  = 3'd7
   } op_e;

   // control FSM states, slt and the branches visit both passes
   typedef enum logic [1:0] {
      ST_FETCH = 2'd0,
      ST_PASS1 = 2'd1,
      ST_PASS2 = 2'd2
   } state_e;

   // decoded instruction fields, the immediate travels serially instead
   typedef struct packed {
      op_e              op;
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs1;
      logic [REG_W-1:0] rs2;
   } instr_t;

   // bit counter status shared by the FSM and the datapath
   typedef struct packed {
      // counter is running, one data bit per cycle
      logic en;
      // bit 0 is on the serial lines
      logic first;
      // bit 31 is on the serial lines
      logic last;
      // single cycle pulse right after the last bit
      logic done;
   } cnt_t;

endpackage

/* src/serial_counter.sv */
`timescale 1ns/1ps

module serial_counter (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_start,
   output serial_pkg::cnt_t o_cnt
);

   // bits 4..2 of the bit index as a plain binary counter
   logic [2:0] cnt_hi;
   // bits 1..0 of the bit index as a one-hot ring of four
   logic [3:0] cnt_ring;
   logic       cnt_last;
   logic       cnt_done;

   // bit 31 is the fourth ring slot of the eighth group
   assign cnt_last = (cnt_hi == 3'd7) & cnt_ring[3];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_hi   <= 3'd0;
         cnt_ring <= 4'b0000;
         cnt_done <= 1'b0;
      end else begin
         // every wrap of the ring bumps the upper part, 7 rolls over to 0
         cnt_hi   <= cnt_hi + {2'd0, cnt_ring[3]};
         // the token is not fed back after bit 31, so the ring empties and
         // the count stops by itself; a start pulse injects a new token
         cnt_ring <= {cnt_ring[2:0], (cnt_ring[3] & ~cnt_last) | i_start};
         cnt_done <= cnt_last;
      end
   end

   // no separate enable flop, any token in the ring means running
   assign o_cnt.en    = |cnt_ring;
   assign o_cnt.first = (cnt_hi == 3'd0) & cnt_ring[0];
   assign o_cnt.last  = cnt_last;
   assign o_cnt.done  = cnt_done;

endmodule

/* src/serial_state.sv */
`timescale 1ns/1ps

module serial_state (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_ibus_ack,
   input  serial_pkg::instr_t i_instr,
   input  serial_pkg::cnt_t   i_cnt,
   input  logic               i_cmp_flag,
   output logic               o_ibus_cyc,
   output logic               o_cnt_start,
   output logic               o_rf_wen,
   output logic               o_pc_en,
   output logic               o_jump,
   output logic               o_out_en,
   output logic               o_pass2
);

   import serial_pkg::*;

   state_e state;
   logic   start_r;
   logic   jump_r;
   logic   two_pass;
   logic   writes_rd;
   logic   take_branch;
   logic   final_pass;

   // slt and the branches need the compare flag before anything is written
   assign two_pass = (i_instr.op == OP_SLT) | (i_instr.op == OP_BEQ) |
                     (i_instr.op == OP_BNE);

   // operations that write rd in their single pass
   assign writes_rd = (i_instr.op == OP_ADD) | (i_instr.op == OP_SUB) |
                      (i_instr.op == OP_ADDI) | (i_instr.op == OP_JAL);

   // flag means equal after pass one, bne wants the opposite
   assign take_branch = (i_instr.op == OP_JAL) |
                        ((i_instr.op == OP_BEQ) & i_cmp_flag) |
                        ((i_instr.op == OP_BNE) & ~i_cmp_flag);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state   <= ST_FETCH;
         start_r <= 1'b0;
         jump_r  <= 1'b0;
      end else begin
         // start is a one cycle strobe unless a transition below sets it
         start_r <= 1'b0;
         case (state)
            ST_FETCH: begin
               // decode latches the word on this same ack cycle
               if (i_ibus_ack) begin
                  state   <= ST_PASS1;
                  start_r <= 1'b1;
               end
            end
            ST_PASS1: begin
               if (i_cnt.done) begin
                  if (two_pass) begin
                     state   <= ST_PASS2;
                     start_r <= 1'b1;
                     jump_r  <= take_branch;
                  end else begin
                     state <= ST_FETCH;
                  end
               end
            end
            ST_PASS2: begin
               if (i_cnt.done) begin
                  state <= ST_FETCH;
               end
            end
            default: begin
               state <= ST_FETCH;
            end
         endcase
      end
   end

   // the pc is rewritten in the last pass of every instruction
   assign final_pass = ((state == ST_PASS1) & ~two_pass) | (state == ST_PASS2);

   // the bus request is simply the fetch state, it drops after the ack
   assign o_ibus_cyc  = (state == ST_FETCH);
   assign o_cnt_start = start_r;
   assign o_pass2     = (state == ST_PASS2);
   assign o_pc_en     = final_pass;

   // jal jumps in its only pass, beq and bne use the decision from pass one
   assign o_jump = ((state == ST_PASS1) & (i_instr.op == OP_JAL)) |
                   ((state == ST_PASS2) & jump_r);

   // slt writes its flag in pass two; branches and out never write rd
   assign o_rf_wen = ((state == ST_PASS1) & ~two_pass & writes_rd) |
                     ((state == ST_PASS2) & (i_instr.op == OP_SLT));

   // out has a single pass, the port register is full when it ends
   assign o_out_en = (state == ST_PASS1) & (i_instr.op == OP_OUT) & i_cnt.done;

endmodule

/* src/serial_decode.sv */
`timescale 1ns/1ps

module serial_decode (
   input  logic                        i_clk,
   input  logic                        i_ibus_ack,
   input  logic [serial_pkg::XLEN-1:0] i_ibus_rdt,
   input  serial_pkg::cnt_t            i_cnt,
   output serial_pkg::instr_t          o_instr,
   output logic                        o_imm_bit
);

   import serial_pkg::*;

   instr_t     instr_r;
   // raw immediate kept for the reload before each pass
   logic [11:0] imm_raw;
   // serial immediate, bit 0 is the one on the line
   logic [11:0] imm_sr;

   always_ff @(posedge i_clk) begin
      // fields come straight from the word, bits 19..12 are not used
      if (i_ibus_ack) begin
         instr_r.op  <= op_e'(i_ibus_rdt[31:29]);
         instr_r.rd  <= i_ibus_rdt[28:26];
         instr_r.rs1 <= i_ibus_rdt[25:23];
         instr_r.rs2 <= i_ibus_rdt[22:20];
         imm_raw     <= i_ibus_rdt[11:0];
      end

      // arithmetic shift right, once the 12 bits are used the sign repeats
      // for the upper 20 bits; between passes the shifter is reloaded so
      // bit 0 is ready when the counter starts
      if (i_cnt.en) begin
         imm_sr <= {imm_sr[11], imm_sr[11:1]};
      end else begin
         imm_sr <= imm_raw;
      end
   end

   assign o_instr   = instr_r;
   assign o_imm_bit = imm_sr[0];

endmodule

/* src/serial_regfile.sv */
`timescale 1ns/1ps

module serial_regfile (
   input  logic               i_clk,
   input  serial_pkg::cnt_t   i_cnt,
   input  serial_pkg::instr_t i_instr,
   input  logic               i_wen,
   input  logic               i_wdata,
   output logic               o_rs1_bit,
   output logic               o_rs2_bit
);

   import serial_pkg::*;

   // each register is a ring, bit 0 is the one presented on the read ports
   logic [XLEN-1:0] regs [NREGS];
   logic [NREGS-1:0] wsel;

   // one write select per register, x0 is never selected
   always_comb begin
      wsel = '0;
      for (int i = 1; i < NREGS; i++) begin
         wsel[i] = i_wen & (i_instr.rd == REG_W'(i));
      end
   end

   // all registers rotate together so a full pass brings them back into place
   always_ff @(posedge i_clk) begin
      if (i_cnt.en) begin
         for (int i = 0; i < NREGS; i++) begin
            // the written register takes the new bit instead of its own one
            if (wsel[i]) begin
               regs[i] <= {i_wdata, regs[i][XLEN-1:1]};
            end else begin
               regs[i] <= {regs[i][0], regs[i][XLEN-1:1]};
            end
         end
      end
   end

   // x0 may hold anything, its reads are forced to zero
   assign o_rs1_bit = (i_instr.rs1 == '0) ? 1'b0 : regs[i_instr.rs1][0];
   assign o_rs2_bit = (i_instr.rs2 == '0) ? 1'b0 : regs[i_instr.rs2][0];

endmodule

/* src/serial_exec.sv */
`timescale 1ns/1ps

module serial_exec (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  serial_pkg::cnt_t            i_cnt,
   input  serial_pkg::instr_t          i_instr,
   input  logic                        i_rs1_bit,
   input  logic                        i_rs2_bit,
   input  logic                        i_imm_bit,
   input  logic                        i_pc4_bit,
   input  logic                        i_pass2,
   input  logic                        i_out_en,
   output logic                        o_rd_bit,
   output logic                        o_cmp_flag,
   output logic                        o_out_valid,
   output logic [serial_pkg::XLEN-1:0] o_out_data
);

   import serial_pkg::*;

   logic            sub;
   logic            op_b;
   logic            carry;
   logic            c_in;
   logic            c_out;
   logic            sum;
   logic            flag;
   logic [XLEN-1:0] out_sr;

   // slt is a subtraction whose sign decides the result
   assign sub  = (i_instr.op == OP_SUB) | (i_instr.op == OP_SLT);
   assign op_b = ((i_instr.op == OP_ADDI) ? i_imm_bit : i_rs2_bit) ^ sub;

   // a - b is a + ~b + 1, the +1 is the carry preset on bit 0
   assign c_in  = i_cnt.first ? sub : carry;
   assign sum   = i_rs1_bit ^ op_b ^ c_in;
   assign c_out = (i_rs1_bit & op_b) | (c_in & (i_rs1_bit ^ op_b));

   always_ff @(posedge i_clk) begin
      if (i_cnt.en) begin
         carry <= c_out;
      end

      // flag is frozen in pass two so the FSM and slt can use it
      if (i_cnt.en & ~i_pass2) begin
         if (i_instr.op == OP_SLT) begin
            // less than is the sign corrected by the signed overflow
            if (i_cnt.last) begin
               flag <= sum ^ (c_in ^ c_out);
            end
         end else begin
            // equal until any bit pair differs
            flag <= (i_cnt.first | flag) & ~(i_rs1_bit ^ i_rs2_bit);
         end
      end

      // rs1 enters from the top, after 32 bits it sits in place
      if (i_cnt.en & (i_instr.op == OP_OUT)) begin
         out_sr <= {i_rs1_bit, out_sr[XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_out_valid <= 1'b0;
      end else begin
         o_out_valid <= i_out_en;
      end
   end

   always_comb begin
      case (i_instr.op)
         OP_ADD, OP_SUB, OP_ADDI: o_rd_bit = sum;
         OP_JAL:                  o_rd_bit = i_pc4_bit;
         // the flag becomes bit 0 of rd, all upper bits are zero
         OP_SLT:                  o_rd_bit = i_cnt.first & flag;
         default:                 o_rd_bit = 1'b0;
      endcase
   end

   assign o_cmp_flag = flag;
   assign o_out_data = out_sr;

endmodule

/* src/serial_pc.sv */
`timescale 1ns/1ps

module serial_pc (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  serial_pkg::cnt_t            i_cnt,
   input  logic                        i_pc_en,
   input  logic                        i_jump,
   input  logic                        i_imm_bit,
   output logic [serial_pkg::XLEN-1:0] o_pc,
   output logic                        o_pc4_bit
);

   import serial_pkg::*;

   logic [XLEN-1:0] pc;
   // first delayed twice marks bit 2, where the 4 is added
   logic [1:0]      first_dly;
   // immediate delayed twice is the word offset in bytes
   logic [1:0]      imm_dly;
   logic            c4;
   logic            cj;
   logic            c4_in;
   logic            cj_in;
   logic            four_bit;
   logic            off_bit;
   logic            pcj_bit;

   assign four_bit = first_dly[0];
   assign off_bit  = imm_dly[0];

   // both adders restart with no carry on bit 0
   assign c4_in = i_cnt.first ? 1'b0 : c4;
   assign cj_in = i_cnt.first ? 1'b0 : cj;

   assign o_pc4_bit = pc[0] ^ four_bit ^ c4_in;
   assign pcj_bit   = pc[0] ^ off_bit ^ cj_in;

   always_ff @(posedge i_clk) begin
      first_dly <= {i_cnt.first, first_dly[1]};
      // zeros come in while idle, so bits 0 and 1 of the offset are zero
      imm_dly   <= {i_imm_bit & i_cnt.en, imm_dly[1]};
      if (i_cnt.en) begin
         c4 <= (pc[0] & four_bit) | (c4_in & (pc[0] ^ four_bit));
         cj <= (pc[0] & off_bit) | (cj_in & (pc[0] ^ off_bit));
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else if (i_pc_en & i_cnt.en) begin
         // the pc rotates like a register file entry and takes the new value
         pc <= {(i_jump ? pcj_bit : o_pc4_bit), pc[XLEN-1:1]};
      end
   end

   // valid in parallel whenever the pc is not rotating
   assign o_pc = pc;

endmodule

/* src/serial_core.sv */
`timescale 1ns/1ps

module serial_core (
   input  logic                        i_clk,
   input  logic                        i_rst,
   output logic [serial_pkg::XLEN-1:0] o_ibus_adr,
   output logic                        o_ibus_cyc,
   input  logic                        i_ibus_ack,
   input  logic [serial_pkg::XLEN-1:0] i_ibus_rdt,
   output logic                        o_out_valid,
   output logic [serial_pkg::XLEN-1:0] o_out_data
);

   import serial_pkg::*;

   instr_t instr;
   cnt_t   cnt;
   logic   cnt_start;
   logic   rf_wen;
   logic   pc_en;
   logic   jump;
   logic   out_en;
   logic   pass2;
   logic   cmp_flag;
   logic   imm_bit;
   logic   rs1_bit;
   logic   rs2_bit;
   logic   rd_bit;
   logic   pc4_bit;

   serial_counter u_counter (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (cnt_start),
      .o_cnt   (cnt)
   );

   serial_state u_state (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_instr     (instr),
      .i_cnt       (cnt),
      .i_cmp_flag  (cmp_flag),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_cnt_start (cnt_start),
      .o_rf_wen    (rf_wen),
      .o_pc_en     (pc_en),
      .o_jump      (jump),
      .o_out_en    (out_en),
      .o_pass2     (pass2)
   );

   serial_decode u_decode (
      .i_clk      (i_clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt      (cnt),
      .o_instr    (instr),
      .o_imm_bit  (imm_bit)
   );

   serial_regfile u_regfile (
      .i_clk     (i_clk),
      .i_cnt     (cnt),
      .i_instr   (instr),
      .i_wen     (rf_wen),
      .i_wdata   (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_exec u_exec (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cnt       (cnt),
      .i_instr     (instr),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .i_imm_bit   (imm_bit),
      .i_pc4_bit   (pc4_bit),
      .i_pass2     (pass2),
      .i_out_en    (out_en),
      .o_rd_bit    (rd_bit),
      .o_cmp_flag  (cmp_flag),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data)
   );

   // the fetch address is the parallel pc register
   serial_pc u_pc (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_cnt     (cnt),
      .i_pc_en   (pc_en),
      .i_jump    (jump),
      .i_imm_bit (imm_bit),
      .o_pc      (o_ibus_adr),
      .o_pc4_bit (pc4_bit)
   );

endmodule

/* bench/tb_serial_core.sv */
`timescale 1ns/1ps

module tb_serial_core;

   import serial_pkg::*;

   // program is 7 register setups, 50 random instructions and a final loop
   localparam int PROG_LEN  = 58;
   localparam int LAST      = PROG_LEN - 1;
   localparam int MAX_FETCH = 60;
   // worst case is a two-pass instruction with the longest ack wait each time
   localparam int TIMEOUT_CYCLES = MAX_FETCH * (68 + 4) + 10 + 200;

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic        ibus_ack;
   logic [31:0] ibus_rdt;
   logic        out_valid;
   logic [31:0] out_data;

   logic [31:0] prog [PROG_LEN];
   logic [1:0]  ack_wait [MAX_FETCH];
   bit          seen [PROG_LEN];
   logic [31:0] mx [NREGS];
   logic [31:0] model_pc;
   logic [31:0] exp_out [$];
   logic [1:0]  wait_left;
   int          fetch_cnt;
   int          strobe_cnt;
   int          model_outs;
   int          cycle_cnt;
   bit          run_done;

   serial_core DUT (
      .i_clk       (clk),
      .i_rst       (rst),
      .o_ibus_adr  (ibus_adr),
      .o_ibus_cyc  (ibus_cyc),
      .i_ibus_ack  (ibus_ack),
      .i_ibus_rdt  (ibus_rdt),
      .o_out_valid (out_valid),
      .o_out_data  (out_data)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic end_with_failure();
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
         end_with_failure();
      end
   endtask

   // opcode, rd, rs1, rs2, ignored byte and the 12-bit immediate
   function automatic logic [31:0] encode(input logic [2:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs1, input logic [2:0] rs2,
                                          input logic [7:0] junk, input logic [11:0] imm);
      return {op, rd, rs1, rs2, junk, imm};
   endfunction

   task automatic build_program();
      logic [31:0] r;
      logic [2:0]  op;
      logic [2:0]  rs1;
      logic [2:0]  rs2;
      logic [11:0] imm;
      int          off;
      // every register gets a defined value before it is used
      for (int i = 0; i < 7; i++) begin
         r = $urandom;
         prog[i] = encode(OP_ADDI, 3'(i + 1), 3'd0, 3'd0, 8'd0, r[11:0]);
      end
      for (int i = 7; i < LAST; i++) begin
         r = $urandom;
         op  = r[31:29];
         rs1 = r[25:23];
         rs2 = r[22:20];
         imm = r[11:0];
         if (op == OP_BEQ || op == OP_BNE || op == OP_JAL) begin
            // about half of the compares use one register twice so beq is taken
            if (r[19]) begin
               rs2 = rs1;
            end
            // forward jumps only, never beyond the final loop
            off = int'(r[13:12]) % 3 + 1;
            if (i + off > LAST) begin
               off = LAST - i;
            end
            imm = off[11:0];
         end
         prog[i] = encode(op, r[28:26], rs1, rs2, r[19:12], imm);
      end
      prog[LAST] = encode(OP_JAL, 3'd0, 3'd0, 3'd0, 8'd0, 12'd0);
      for (int i = 0; i < MAX_FETCH; i++) begin
         r = $urandom;
         ack_wait[i] = r[1:0];
      end
   endtask

   // ISA model, one call per fetched instruction
   task automatic execute_model(input logic [31:0] w);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [31:0] next_pc;
      logic        wr;
      a       = mx[w[25:23]];
      b       = mx[w[22:20]];
      imm     = {{20{w[11]}}, w[11:0]};
      next_pc = model_pc + 32'd4;
      res     = '0;
      wr      = 1'b1;
      case (op_e'(w[31:29]))
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_ADDI: res = a + imm;
         OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_BEQ: begin
            wr = 1'b0;
            if (a == b) begin
               next_pc = model_pc + (imm << 2);
            end
         end
         OP_BNE: begin
            wr = 1'b0;
            if (a != b) begin
               next_pc = model_pc + (imm << 2);
            end
         end
         OP_JAL: begin
            res     = next_pc;
            next_pc = model_pc + (imm << 2);
         end
         default: begin
            wr = 1'b0;
            exp_out.push_back(a);
            model_outs = model_outs + 1;
         end
      endcase
      // x0 keeps its zero whatever is written to it
      if (wr && w[28:26] != 3'd0) begin
         mx[w[28:26]] = res;
      end
      model_pc = next_pc;
   endtask

   task automatic serve_fetch();
      int idx;
      idx = int'(ibus_adr[31:2]);
      if (seen[idx] && idx != LAST) begin
         $display("address 0x%08h was fetched a second time", ibus_adr);
         end_with_failure();
      end
      check_value("o_ibus_adr", ibus_adr, model_pc);
      if (seen[idx]) begin
         run_done = 1'b1;
      end else begin
         seen[idx] = 1'b1;
         execute_model(prog[idx]);
      end
      ibus_rdt  <= prog[idx];
      ibus_ack  <= 1'b1;
      fetch_cnt = fetch_cnt + 1;
      wait_left = (fetch_cnt < MAX_FETCH) ? ack_wait[fetch_cnt] : 2'd0;
   endtask

   task automatic check_strobe();
      logic [31:0] exp;
      if (exp_out.size() == 0) begin
         $display("an output strobe came without an out instruction behind it");
         end_with_failure();
      end
      exp = exp_out.pop_front();
      check_value("o_out_data", out_data, exp);
      strobe_cnt = strobe_cnt + 1;
   endtask

   // memory and output port side, all inputs change on the rising edge
   always @(posedge clk) begin
      if (rst) begin
         ibus_ack <= 1'b0;
      end else begin
         // the strobe is handled first, its value was queued at an earlier fetch
         if (out_valid) begin
            check_strobe();
         end
         if (ibus_ack) begin
            ibus_ack <= 1'b0;
         end else if (ibus_cyc && !run_done) begin
            if (wait_left == 2'd0) begin
               serve_fetch();
            end else begin
               wait_left = wait_left - 2'd1;
            end
         end
      end
   end

   initial begin
      rst      <= 1'b1;
      ibus_ack <= 1'b0;
      ibus_rdt <= '0;
      void'($urandom(51448));
      for (int i = 0; i < NREGS; i++) begin
         mx[i] = '0;
      end
      model_pc   = '0;
      fetch_cnt  = 0;
      strobe_cnt = 0;
      model_outs = 0;
      cycle_cnt  = 0;
      run_done   = 1'b0;
      build_program();
      wait_left = ack_wait[0];
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      while (!run_done && cycle_cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
      end
      if (!run_done) begin
         $display("timeout: the core stopped fetching after %0d cycles", cycle_cnt);
         end_with_failure();
      end else begin
         check_value("out strobe count", 32'(strobe_cnt), 32'(model_outs));
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

/* project.f */
src/serial_pkg.sv
src/serial_counter.sv
src/serial_state.sv
src/serial_decode.sv
src/serial_regfile.sv
src/serial_exec.sv
src/serial_pc.sv
src/serial_core.sv
bench/tb_serial_core.sv

/* run.sh */
#!/usr/bin/env bash
# compile the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_serial_core --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_serial_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the run passes only if the testbench printed its pass line
if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
